/* capture_ctrl.sv */
// -------------------------------------------------------------------
// capture FSM and write pointer, one sample per tick
// -------------------------------------------------------------------
`timescale 1ns/1ps

module capture_ctrl import sump_pkg::*; (
  input  logic              clk_80m,
  input  logic              arst_n,
  input  logic              tick,         // 1 MHz sample strobe
  input  logic [word_w-1:0] sample_word,
  cap_ctrl_if.cap           ctrl,
  cap_ram_if.writer         ram
);

  logic wr_go;  // store this cycle

  // arm and stop win over a tick landing in the same cycle
  assign wr_go = (ctrl.state == st_armed) && tick && !ctrl.arm && !ctrl.stop;

  // -----------------------------------------------------------------
  // state and count
  // -----------------------------------------------------------------
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.state    <= st_idle;
      ctrl.wr_count <= '0;
    end else if (ctrl.arm) begin
      // also restarts a capture in progress
      ctrl.wr_count <= '0;
      ctrl.state    <= st_armed;
    end else if (ctrl.stop) begin
      ctrl.state <= st_idle;  // count kept for status
    end else if (wr_go) begin
      ctrl.wr_count <= ctrl.wr_count + 1'b1;
      if (ctrl.wr_count == cnt_w'(ram_depth - 1)) begin
        ctrl.state <= st_done;  // last location written
      end
    end
  end

  // -----------------------------------------------------------------
  // ram write port
  // -----------------------------------------------------------------
  assign ram.wr_en   = wr_go;
  assign ram.wr_addr = ctrl.wr_count[ram_addr_w-1:0];  // 0..255 while armed
  assign ram.wr_data = sample_word;

endmodule

/* capture_ram.sv */
// -------------------------------------------------------------------
// 256 x 32 sample memory, registered read
// -------------------------------------------------------------------
`timescale 1ns/1ps

module capture_ram import sump_pkg::*; (
  input  logic   clk_80m,
  cap_ram_if.mem ram
);

  logic [word_w-1:0] mem [ram_depth];

  // write port
  always_ff @(posedge clk_80m) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // read port, data one cycle after address
  always_ff @(posedge clk_80m) begin
    ram.rd_data <= mem[ram.rd_addr];
  end

endmodule

/* la_if.sv */
// -------------------------------------------------------------------
// capture control and capture RAM interfaces
// -------------------------------------------------------------------
`timescale 1ns/1ps

// control strobes and capture status between bus regs and capture FSM
interface cap_ctrl_if import sump_pkg::*; ();

  logic             arm;       // one cycle strobe
  logic             stop;      // one cycle strobe
  src_sel_t         src_sel;   // probe word source
  cap_state_t       state;
  logic [cnt_w-1:0] wr_count;  // samples stored, 0..256

  // bus register side
  modport lb (
    output arm,
    output stop,
    output src_sel,
    input  state,
    input  wr_count
  );

  // capture FSM side
  modport cap (
    input  arm,
    input  stop,
    output state,
    output wr_count
  );

  modport fmt (input src_sel);  // probe formatter only needs the source

endinterface

// sample memory, write side from capture FSM, read side from bus regs
interface cap_ram_if import sump_pkg::*; ();

  logic                  wr_en;
  logic [ram_addr_w-1:0] wr_addr;
  logic [word_w-1:0]     wr_data;
  logic [ram_addr_w-1:0] rd_addr;
  logic [word_w-1:0]     rd_data;  // registered, 1 cycle after rd_addr

  modport writer (output wr_en, output wr_addr, output wr_data);
  modport mem    (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);
  modport reader (output rd_addr, input rd_data);

endinterface

/* la_top.sv */
// -------------------------------------------------------------------
// logic analyzer capture block, top level
// -------------------------------------------------------------------
`timescale 1ns/1ps

module la_top import sump_pkg::*; (
  input  logic                  clk_80m,
  input  logic                  arst_n,
  // local bus
  input  logic                  lb_cs_ctrl,
  input  logic                  lb_cs_data,
  input  logic                  lb_wr,
  input  logic                  lb_rd,
  input  logic [word_w-1:0]     lb_wr_d,
  output logic [word_w-1:0]     lb_rd_d,
  output logic                  lb_rd_rdy,
  // probes
  input  logic                  psu_fault,
  input  logic                  psu_good,
  input  logic [fsm_w-1:0]      psu_fsm,
  input  logic                  tx_cadence,
  input  logic                  tx_waveform,
  input  logic                  tx_receive,
  input  logic [tx_index_w-1:0] tx_index,
  input  logic [adc_w-1:0]      adc_a,
  input  logic [adc_w-1:0]      adc_b
);

  logic              tick;         // 1 MHz sample strobe
  logic [ts_w-1:0]   timestamp;
  logic [word_w-1:0] sample_word;

  cap_ctrl_if i_cap_ctrl_if ();
  cap_ram_if  i_cap_ram_if ();

  // -----------------------------------------------------------------
  // time base and probe path
  // -----------------------------------------------------------------
  time_base i_time_base (
    .clk_80m   (clk_80m),
    .arst_n    (arst_n),
    .tick      (tick),
    .timestamp (timestamp)
  );

  probe_format i_probe_format (
    .clk_80m     (clk_80m),
    .arst_n      (arst_n),
    .psu_fault   (psu_fault),
    .psu_good    (psu_good),
    .psu_fsm     (psu_fsm),
    .tx_cadence  (tx_cadence),
    .tx_waveform (tx_waveform),
    .tx_receive  (tx_receive),
    .tx_index    (tx_index),
    .adc_a       (adc_a),
    .adc_b       (adc_b),
    .ctrl        (i_cap_ctrl_if.fmt),
    .sample_word (sample_word)
  );

  // -----------------------------------------------------------------
  // capture and bus
  // -----------------------------------------------------------------
  capture_ctrl i_capture_ctrl (
    .clk_80m     (clk_80m),
    .arst_n      (arst_n),
    .tick        (tick),
    .sample_word (sample_word),
    .ctrl        (i_cap_ctrl_if.cap),
    .ram         (i_cap_ram_if.writer)
  );

  capture_ram i_capture_ram (
    .clk_80m (clk_80m),
    .ram     (i_cap_ram_if.mem)
  );

  lb_regs i_lb_regs (
    .clk_80m    (clk_80m),
    .arst_n     (arst_n),
    .lb_cs_ctrl (lb_cs_ctrl),
    .lb_cs_data (lb_cs_data),
    .lb_wr      (lb_wr),
    .lb_rd      (lb_rd),
    .lb_wr_d    (lb_wr_d),
    .lb_rd_d    (lb_rd_d),
    .lb_rd_rdy  (lb_rd_rdy),
    .timestamp  (timestamp),
    .ctrl       (i_cap_ctrl_if.lb),
    .ram        (i_cap_ram_if.reader)
  );

endmodule

/* la_top_checker.sv */
// -------------------------------------------------------------------
// bound assertions on local bus read timing and the 1 MHz tick
// -------------------------------------------------------------------
`timescale 1ns/1ps

module la_top_checker import sump_pkg::*; (
  input logic clk_80m,
  input logic arst_n,
  input logic lb_cs_ctrl,
  input logic lb_cs_data,
  input logic lb_rd,
  input logic lb_rd_rdy,
  input logic tick
);

  int unsigned fails_late = 0;     // strobe without ready 2 cycles on
  int unsigned fails_spurious = 0; // ready without a strobe 2 cycles back
  int unsigned fails_tick = 0;     // tick period off
  int unsigned fail_cnt;
  int          gap;                // cycles since the last tick
  logic        tick_seen;
  logic        rd_strobe;

  assign rd_strobe = lb_rd && (lb_cs_ctrl || lb_cs_data);
  assign fail_cnt  = fails_late + fails_spurious + fails_tick;

  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      gap       <= 0;
      tick_seen <= 1'b0;
    end else begin
      gap       <= tick ? 0 : gap + 1;
      tick_seen <= tick_seen || tick;  // first period after reset is not checked
    end
  end

  // -------------------------------------------------------------------
  // read handshake
  // -------------------------------------------------------------------
  a_rdy_after_rd: assert property (@(posedge clk_80m) disable iff (!arst_n)
    $past(rd_strobe, 2) |-> lb_rd_rdy)
  else begin
    $error("lb_rd_rdy missing 2 cycles after a read strobe");
    fails_late++;
  end

  a_rdy_has_rd: assert property (@(posedge clk_80m) disable iff (!arst_n)
    lb_rd_rdy |-> $past(rd_strobe, 2))
  else begin
    $error("lb_rd_rdy without a read strobe 2 cycles earlier");
    fails_spurious++;
  end

  // tick exactly every clk_mhz cycles
  a_tick_period: assert property (@(posedge clk_80m) disable iff (!arst_n)
    tick_seen |-> (tick == (gap == clk_mhz - 1)))
  else begin
    $error("tick period differs from %0d cycles", clk_mhz);
    fails_tick++;
  end

endmodule

bind la_top la_top_checker i_la_top_checker (
  .clk_80m    (clk_80m),
  .arst_n     (arst_n),
  .lb_cs_ctrl (lb_cs_ctrl),
  .lb_cs_data (lb_cs_data),
  .lb_rd      (lb_rd),
  .lb_rd_rdy  (lb_rd_rdy),
  .tick       (tick)
);

/* lb_regs.sv */
// -------------------------------------------------------------------
// local bus decode, control opcodes, read pointer and read pipeline
// -------------------------------------------------------------------
`timescale 1ns/1ps

module lb_regs import sump_pkg::*; (
  input  logic              clk_80m,
  input  logic              arst_n,
  input  logic              lb_cs_ctrl,
  input  logic              lb_cs_data,
  input  logic              lb_wr,
  input  logic              lb_rd,
  input  logic [word_w-1:0] lb_wr_d,
  output logic [word_w-1:0] lb_rd_d,
  output logic              lb_rd_rdy,   // 2 cycles after lb_rd
  input  logic [ts_w-1:0]   timestamp,
  cap_ctrl_if.lb            ctrl,
  cap_ram_if.reader         ram
);

  lb_opcode_t            opcode;
  logic                  ctrl_wr;
  logic                  ctrl_rd;
  logic                  data_wr;
  logic                  data_rd;
  rd_sel_t               rd_sel;      // what a control read returns
  logic [ram_addr_w-1:0] rd_ptr;
  logic [word_w-1:0]     status_word;
  logic [word_w-1:0]     ctrl_word;
  logic                  rd_vld_p1;   // read in flight, stage 1
  logic                  rd_data_p1;  // stage 1 targets the RAM
  logic [word_w-1:0]     snap_p1;     // status or time at the strobe

  assign ctrl_wr = lb_cs_ctrl && lb_wr;
  assign ctrl_rd = lb_cs_ctrl && lb_rd;
  assign data_wr = lb_cs_data && lb_wr;
  assign data_rd = lb_cs_data && lb_rd;
  assign opcode  = lb_opcode_t'(lb_wr_d[op_w-1:0]);

  // -----------------------------------------------------------------
  // control opcodes
  // -----------------------------------------------------------------
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.arm     <= 1'b0;
      ctrl.stop    <= 1'b0;
      ctrl.src_sel <= src_dig;
      rd_sel       <= rdsel_status;
    end else begin
      ctrl.arm  <= 1'b0;  // strobes last one cycle
      ctrl.stop <= 1'b0;
      if (ctrl_wr) begin
        case (opcode)
          op_nop:       ;
          op_arm:       ctrl.arm     <= 1'b1;
          op_stop:      ctrl.stop    <= 1'b1;
          op_src_dig:   ctrl.src_sel <= src_dig;
          op_src_ana:   ctrl.src_sel <= src_ana;
          op_rd_status: rd_sel       <= rdsel_status;
          op_rd_time:   rd_sel       <= rdsel_time;
          default:      ;  // unused codes ignored
        endcase
      end
    end
  end

  // read pointer, loaded by data write, bumped per data read
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (data_wr) begin
      rd_ptr <= lb_wr_d[ram_addr_w-1:0];
    end else if (data_rd) begin
      rd_ptr <= rd_ptr + 1'b1;  // wraps at 256
    end
  end

  assign ram.rd_addr = rd_ptr;

  always_comb begin
    status_word                             = '0;
    status_word[stat_state_lsb +: 2]        = ctrl.state;
    status_word[stat_src_bit]               = ctrl.src_sel;
    status_word[stat_count_lsb +: cnt_w]    = ctrl.wr_count;
  end

  assign ctrl_word = (rd_sel == rdsel_time) ? word_w'(timestamp) : status_word;

  // -----------------------------------------------------------------
  // two stage read pipeline, RAM data lands in stage 1
  // -----------------------------------------------------------------
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld_p1  <= 1'b0;
      rd_data_p1 <= 1'b0;
      lb_rd_rdy  <= 1'b0;
    end else begin
      rd_vld_p1  <= ctrl_rd || data_rd;
      rd_data_p1 <= data_rd;
      lb_rd_rdy  <= rd_vld_p1;
    end
  end

  always_ff @(posedge clk_80m) begin
    snap_p1 <= ctrl_word;
    lb_rd_d <= rd_data_p1 ? ram.rd_data : snap_p1;  // valid with lb_rd_rdy
  end

endmodule

/* list.f */
sump_pkg.sv
la_if.sv
time_base.sv
probe_format.sv
capture_ctrl.sv
capture_ram.sv
lb_regs.sv
la_top.sv
la_top_checker.sv
tb_la_top.sv

/* probe_format.sv */
// -------------------------------------------------------------------
// probe word formatter, digital or analog sample word
// -------------------------------------------------------------------
`timescale 1ns/1ps

module probe_format import sump_pkg::*; (
  input  logic                  clk_80m,
  input  logic                  arst_n,
  input  logic                  psu_fault,
  input  logic                  psu_good,
  input  logic [fsm_w-1:0]      psu_fsm,
  input  logic                  tx_cadence,
  input  logic                  tx_waveform,
  input  logic                  tx_receive,
  input  logic [tx_index_w-1:0] tx_index,
  input  logic [adc_w-1:0]      adc_a,
  input  logic [adc_w-1:0]      adc_b,
  cap_ctrl_if.fmt               ctrl,
  output logic [word_w-1:0]     sample_word
);

  logic [fsm_states-1:0] fsm_onehot;
  logic [word_w-1:0]     dig_word;
  logic [word_w-1:0]     ana_word;

  // one flag per PSU state code
  assign fsm_onehot = fsm_states'(1) << psu_fsm;

  // low speed digital word
  always_comb begin
    dig_word                                  = '0;
    dig_word[dig_fault_bit]                   = psu_fault;
    dig_word[dig_good_bit]                    = psu_good;
    dig_word[dig_onehot_lsb +: fsm_states]    = fsm_onehot;
    dig_word[dig_cadence_bit]                 = tx_cadence;
    dig_word[dig_waveform_bit]                = tx_waveform;
    dig_word[dig_receive_bit]                 = tx_receive;
    dig_word[dig_index_lsb +: tx_index_w]     = tx_index;
  end

  // analog word, channel id on top, two adc values below
  always_comb begin
    ana_word                          = '0;
    ana_word[ana_id_lsb +: ch_id_w]   = adc_ch_id;
    ana_word[ana_a_lsb +: adc_w]      = adc_a;
    ana_word[ana_b_lsb +: adc_w]      = adc_b;
  end

  // single register stage, probes and source seen 1 cycle later
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      sample_word <= '0;
    end else begin
      sample_word <= (ctrl.src_sel == src_ana) ? ana_word : dig_word;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_la_top -f list.f -o sim_la_top

# keep running after a bound assertion fires so the summary is printed
status=0
out=$(./obj_dir/sim_la_top +verilator+error+limit+1000) || status=$?
echo "$out"
[ "$status" -eq 0 ] || exit "$status"

echo "$out" | grep -qx "Done: no errors"

/* sump_pkg.sv */
// -------------------------------------------------------------------
// shared widths, time constants, enums and sample word layouts
// -------------------------------------------------------------------
package sump_pkg;

  // time base
  localparam int clk_mhz    = 80;               // clk_80m cycles per 1 us tick
  localparam int div_w      = $clog2(clk_mhz);
  localparam int decade     = 10;               // rollover of each decade stage
  localparam int us_per_ms  = 1000;
  localparam int us_w       = 10;               // us field 0..999
  localparam int dec_w      = 4;                // ms, 10ms, 100ms, s fields
  localparam int dec_stages = 4;
  localparam int ts_w       = us_w + dec_stages * dec_w;  // 26

  // capture memory and bus
  localparam int ram_depth  = 256;
  localparam int ram_addr_w = 8;
  localparam int cnt_w      = ram_addr_w + 1;   // write count 0..256
  localparam int word_w     = 32;

  // probes
  localparam int adc_w      = 12;
  localparam int fsm_w      = 3;
  localparam int fsm_states = 2 ** fsm_w;
  localparam int tx_index_w = 8;

  // control opcodes, low nibble of a control write
  localparam int op_w = 4;
  typedef enum logic [op_w-1:0] {
    op_nop       = 4'd0,
    op_arm       = 4'd1,
    op_stop      = 4'd2,
    op_src_dig   = 4'd3,
    op_src_ana   = 4'd4,
    op_rd_status = 4'd5,
    op_rd_time   = 4'd6
  } lb_opcode_t;

  typedef enum logic [1:0] {st_idle = 2'd0, st_armed = 2'd1, st_done = 2'd2} cap_state_t;
  typedef enum logic {src_dig = 1'b0, src_ana = 1'b1} src_sel_t;
  typedef enum logic {rdsel_status = 1'b0, rdsel_time = 1'b1} rd_sel_t;

  // digital word bit positions, 13..23 stay zero
  localparam int dig_fault_bit    = 0;
  localparam int dig_good_bit     = 1;
  localparam int dig_onehot_lsb   = 2;          // 8 one-hot state flags
  localparam int dig_cadence_bit  = 10;
  localparam int dig_waveform_bit = 11;
  localparam int dig_receive_bit  = 12;
  localparam int dig_index_lsb    = 24;

  // analog word, 27..24 stay zero
  localparam int ch_id_w                = 4;
  localparam logic [ch_id_w-1:0] adc_ch_id = 4'd0;
  localparam int ana_id_lsb = 28;
  localparam int ana_a_lsb  = 12;
  localparam int ana_b_lsb  = 0;

  // status word
  localparam int stat_state_lsb = 0;
  localparam int stat_src_bit   = 2;
  localparam int stat_count_lsb = 8;

endpackage

/* tb_la_top.sv */
// -------------------------------------------------------------------
// testbench for la_top, bus tasks, capture and timestamp tests
// -------------------------------------------------------------------
`timescale 1ns/1ps

module tb_la_top import sump_pkg::*; ();

  logic              clk_80m;
  logic              arst_n;
  logic              lb_cs_ctrl;
  logic              lb_cs_data;
  logic              lb_wr;
  logic              lb_rd;
  logic [31:0]       lb_wr_d;
  logic [31:0]       lb_rd_d;
  logic              lb_rd_rdy;
  logic              psu_fault;
  logic              psu_good;
  logic [2:0]        psu_fsm;
  logic              tx_cadence;
  logic              tx_waveform;
  logic              tx_receive;
  logic [7:0]        tx_index;
  logic [11:0]       adc_a;
  logic [11:0]       adc_b;

  int          cyc = 0;       // free running cycle count
  int          rdy_cyc;       // cyc at the last ready pulse
  int          cyc_a;
  int          errors = 0;
  int          test_base;
  int          tests = 0;
  int          failed_tests = 0;
  int          total;
  string       cur_test;
  logic [31:0] word;
  logic [31:0] word2;
  logic [31:0] rd_buf [ram_depth];

  la_top i_la_top (
    .clk_80m     (clk_80m),
    .arst_n      (arst_n),
    .lb_cs_ctrl  (lb_cs_ctrl),
    .lb_cs_data  (lb_cs_data),
    .lb_wr       (lb_wr),
    .lb_rd       (lb_rd),
    .lb_wr_d     (lb_wr_d),
    .lb_rd_d     (lb_rd_d),
    .lb_rd_rdy   (lb_rd_rdy),
    .psu_fault   (psu_fault),
    .psu_good    (psu_good),
    .psu_fsm     (psu_fsm),
    .tx_cadence  (tx_cadence),
    .tx_waveform (tx_waveform),
    .tx_receive  (tx_receive),
    .tx_index    (tx_index),
    .adc_a       (adc_a),
    .adc_b       (adc_b)
  );

  initial begin
    clk_80m = 1'b0;
    forever #5 clk_80m = ~clk_80m;  // 100 MHz sim clock, 80 cycles per tick
  end

  always @(posedge clk_80m) cyc <= cyc + 1;

  // -------------------------------------------------------------------
  // expected words, built from the documented layouts
  // -------------------------------------------------------------------
  function automatic logic [31:0] dig_layout();
    logic [7:0] onehot;
    onehot          = 8'd0;
    onehot[psu_fsm] = 1'b1;
    return {tx_index, 11'd0, tx_receive, tx_waveform, tx_cadence, onehot, psu_good, psu_fault};
  endfunction

  function automatic logic [31:0] ana_layout();
    return {4'd0, 4'd0, adc_a, adc_b};  // channel id 0
  endfunction

  function automatic logic [31:0] status_layout(input logic [1:0] st, input logic src,
                                                input logic [8:0] cnt);
    return {15'd0, cnt, 5'd0, src, st};
  endfunction

  function automatic int ts_to_us(input logic [31:0] t);
    return int'(t[9:0]) + 1000 * (int'(t[13:10]) + 10 * int'(t[17:14])
           + 100 * int'(t[21:18]) + 1000 * int'(t[25:22]));
  endfunction

  function automatic int chk_fails();
    return int'(i_la_top.i_la_top_checker.fail_cnt);  // bound assertion failures
  endfunction

  // -------------------------------------------------------------------
  // checks and test bookkeeping
  // -------------------------------------------------------------------
  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_range(input string what, input int lo, input int hi, input int act);
    assert (act >= lo && act <= hi) else begin
      $display("MISMATCH %s %s: expected %0d..%0d actual %0d", cur_test, what, lo, hi, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_base = errors + chk_fails();
  endtask

  task automatic end_test();
    int n;
    n = errors + chk_fails() - test_base;
    tests++;
    if (n != 0) failed_tests++;
    $display("test %-12s %s (%0d errors)", cur_test, (n == 0) ? "passed" : "FAILED", n);
  endtask

  // -------------------------------------------------------------------
  // bus access, driven on the falling edge
  // -------------------------------------------------------------------
  task automatic bus_write(input logic sel_ctrl, input logic [31:0] data);
    @(negedge clk_80m);
    lb_cs_ctrl = sel_ctrl;
    lb_cs_data = !sel_ctrl;
    lb_wr      = 1'b1;
    lb_wr_d    = data;
    @(negedge clk_80m);
    lb_cs_ctrl = 1'b0;
    lb_cs_data = 1'b0;
    lb_wr      = 1'b0;
    lb_wr_d    = '0;
  endtask

  task automatic bus_read(input logic sel_ctrl, output logic [31:0] data);
    int waited;
    @(negedge clk_80m);
    lb_cs_ctrl = sel_ctrl;
    lb_cs_data = !sel_ctrl;
    lb_rd      = 1'b1;
    @(negedge clk_80m);
    lb_cs_ctrl = 1'b0;
    lb_cs_data = 1'b0;
    lb_rd      = 1'b0;
    waited     = 0;
    while (!lb_rd_rdy && waited < 8) begin
      @(negedge clk_80m);
      waited++;
    end
    data    = lb_rd_d;
    rdy_cyc = cyc;
    if (!lb_rd_rdy) begin
      $display("%s: no read ready within 8 cycles of the read strobe", cur_test);
      errors++;
    end
  endtask

  task automatic issue_reads(input logic sel_ctrl, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_80m);
      lb_cs_ctrl = sel_ctrl;
      lb_cs_data = !sel_ctrl;
      lb_rd      = 1'b1;  // back to back strobes
    end
    @(negedge clk_80m);
    lb_cs_ctrl = 1'b0;
    lb_cs_data = 1'b0;
    lb_rd      = 1'b0;
  endtask

  task automatic collect_reads(input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      @(negedge clk_80m);
      while (!lb_rd_rdy && waited < 8) begin
        @(negedge clk_80m);
        waited++;
      end
      if (!lb_rd_rdy) begin
        $display("%s: read %0d of a burst never became ready", cur_test, i);
        errors++;
        return;
      end
      rd_buf[i] = lb_rd_d;
    end
  endtask

  task automatic read_block();
    bus_write(1'b0, 32'd0);  // read pointer to 0
    fork
      issue_reads(1'b0, ram_depth);
      collect_reads(ram_depth);
    join
  endtask

  task automatic wait_done(output logic [31:0] status);
    int polls;
    polls = 0;
    bus_read(1'b1, status);
    while (status[1:0] != st_done && polls < 400) begin
      repeat (100) @(negedge clk_80m);
      bus_read(1'b1, status);
      polls++;
    end
    if (status[1:0] != st_done) begin
      $display("%s: capture not done after %0d status polls", cur_test, polls);
      errors++;
    end
  endtask

  task automatic randomize_probes();
    logic [31:0] r;
    r = $urandom();
    @(negedge clk_80m);
    psu_fault   = r[0];
    psu_good    = r[1];
    psu_fsm     = r[4:2];
    tx_cadence  = r[5];
    tx_waveform = r[6];
    tx_receive  = r[7];
    tx_index    = r[15:8];
    r           = $urandom();
    adc_a       = r[11:0];
    adc_b       = r[27:16];
  endtask

  task automatic check_ts_fields(input logic [31:0] t);
    check_eq("timestamp unused bits", 32'd0, {t[31:26], 26'd0});
    check_range("us field", 0, 999, int'(t[9:0]));
    for (int i = 0; i < 4; i++) begin
      check_range($sformatf("decade field %0d", i), 0, 9, int'(t[10 + 4*i +: 4]));
    end
  endtask

  // -------------------------------------------------------------------
  // test sequence
  // -------------------------------------------------------------------
  initial begin
    void'($urandom(32'h5648_ebab));
    arst_n = 1'b0;
    lb_cs_ctrl = 1'b0;
    lb_cs_data = 1'b0;
    lb_wr = 1'b0;
    lb_rd = 1'b0;
    lb_wr_d = '0;
    psu_fault = 1'b0;
    psu_good = 1'b0;
    psu_fsm = '0;
    tx_cadence = 1'b0;
    tx_waveform = 1'b0;
    tx_receive = 1'b0;
    tx_index = '0;
    adc_a = '0;
    adc_b = '0;
    repeat (3) @(negedge clk_80m);
    arst_n = 1'b1;

    begin_test("reset_state");
    @(negedge clk_80m);
    check_eq("lb_rd_rdy", 32'd0, {31'd0, lb_rd_rdy});
    bus_read(1'b1, word);
    check_eq("status", status_layout(st_idle, src_dig, 9'd0), word);
    end_test();

    begin_test("read_timing");  // bound checker watches these bursts
    bus_write(1'b0, 32'd0);
    fork
      issue_reads(1'b1, 4);
      collect_reads(4);
    join
    fork
      issue_reads(1'b0, 16);
      collect_reads(16);
    join
    end_test();

    begin_test("dig_capture");
    randomize_probes();
    bus_write(1'b1, 32'(op_src_dig));
    bus_write(1'b1, 32'(op_arm));
    wait_done(word);
    check_eq("status", status_layout(st_done, src_dig, 9'd256), word);
    read_block();
    for (int i = 0; i < ram_depth; i++) begin
      check_eq($sformatf("word %0d", i), dig_layout(), rd_buf[i]);
    end
    end_test();

    begin_test("ana_capture");
    randomize_probes();
    bus_write(1'b1, 32'(op_src_ana));
    bus_write(1'b1, 32'(op_arm));
    wait_done(word);
    check_eq("status", status_layout(st_done, src_ana, 9'd256), word);
    read_block();
    for (int i = 0; i < ram_depth; i++) begin
      check_eq($sformatf("word %0d", i), ana_layout(), rd_buf[i]);
    end
    end_test();

    begin_test("stop");
    bus_write(1'b1, 32'(op_arm));
    repeat (40 * clk_mhz) @(negedge clk_80m);  // about 40 samples
    bus_write(1'b1, 32'(op_stop));
    bus_read(1'b1, word);
    check_eq("state and source", status_layout(st_idle, src_ana, 9'd0), word & 32'hfffe_00ff);
    check_range("count", 1, 255, int'(word[16:8]));
    repeat (20 * clk_mhz) @(negedge clk_80m);
    bus_read(1'b1, word2);
    check_eq("status after 20 us", word, word2);
    end_test();

    begin_test("timestamp");
    bus_write(1'b1, 32'(op_rd_time));
    bus_read(1'b1, word);
    cyc_a = rdy_cyc;
    repeat (3000) @(negedge clk_80m);
    bus_read(1'b1, word2);
    check_ts_fields(word);
    check_ts_fields(word2);
    check_range("us elapsed", (rdy_cyc - cyc_a) / clk_mhz - 1, (rdy_cyc - cyc_a) / clk_mhz + 1,
                ts_to_us(word2) - ts_to_us(word));
    end_test();

    total = errors + chk_fails();
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* time_base.sv */
// -------------------------------------------------------------------
// 1 MHz tick divider and decade counters forming the timestamp
// -------------------------------------------------------------------
`timescale 1ns/1ps

module time_base import sump_pkg::*; (
  input  logic            clk_80m,
  input  logic            arst_n,
  output logic            tick,       // one cycle every clk_mhz cycles
  output logic [ts_w-1:0] timestamp   // {s, 100ms, 10ms, ms, us}
);

  logic [div_w-1:0]      div_cnt;
  logic [us_w-1:0]       us_cnt;
  logic [dec_w-1:0]      dec_cnt [dec_stages];  // 0 = ms ... 3 = s
  logic [dec_stages-1:0] carry;                 // registered carry into each stage
  logic [dec_stages-1:0] wrap;                  // stage at 9 and advancing
  logic                  us_wrap;

  // -----------------------------------------------------------------
  // 80 MHz down to 1 MHz
  // -----------------------------------------------------------------
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= (div_cnt == div_w'(clk_mhz - 1));
      if (div_cnt == div_w'(clk_mhz - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign us_wrap = tick && (us_cnt == us_w'(us_per_ms - 1));  // 999 -> 0

  always_comb begin
    for (int i = 0; i < dec_stages; i++) begin
      wrap[i] = carry[i] && (dec_cnt[i] == dec_w'(decade - 1));
    end
  end

  // -----------------------------------------------------------------
  // us counter then decade chain, each stage one cycle behind its carry
  // -----------------------------------------------------------------
  always_ff @(posedge clk_80m or negedge arst_n) begin
    if (!arst_n) begin
      us_cnt  <= '0;
      carry   <= '0;
      dec_cnt <= '{default: '0};
    end else begin
      if (tick) begin
        us_cnt <= us_wrap ? '0 : us_cnt + 1'b1;
      end
      carry <= {wrap[dec_stages-2:0], us_wrap};  // seconds wrap goes nowhere
      for (int i = 0; i < dec_stages; i++) begin
        if (carry[i]) begin
          dec_cnt[i] <= wrap[i] ? '0 : dec_cnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    timestamp[us_w-1:0] = us_cnt;
    for (int i = 0; i < dec_stages; i++) begin
      timestamp[us_w + i*dec_w +: dec_w] = dec_cnt[i];
    end
  end

endmodule
